//--- hdl/jsp_pkg.sv
// Shared widths, vector types, register map, FSM states and bus structs
package jsp_pkg;

  // Data byte, FIFO fill count (0 to 8), register address
  typedef logic [7:0] byte_t;
  typedef logic [3:0] cnt_t;
  typedef logic [2:0] jsp_adr_t;

  localparam cnt_t FIFO_DEPTH = 4'd8;

  // 16550 register map
  localparam jsp_adr_t ADR_DATA    = 3'd0;
  localparam jsp_adr_t ADR_IER     = 3'd1;
  localparam jsp_adr_t ADR_IIR_FCR = 3'd2;
  localparam jsp_adr_t ADR_LCR     = 3'd3;
  localparam jsp_adr_t ADR_MCR     = 3'd4;
  localparam jsp_adr_t ADR_LSR     = 3'd5;
  localparam jsp_adr_t ADR_MSR     = 3'd6;
  localparam jsp_adr_t ADR_SCR     = 3'd7;

  // Bit positions and fixed values
  localparam int    LCR_DLAB_BIT   = 7;
  localparam int    FCR_RX_CLR_BIT = 1;
  localparam int    FCR_TX_CLR_BIT = 2;
  localparam byte_t MSR_CONST      = 8'h0B;

  // IIR codes
  localparam byte_t IIR_NONE = 8'h01;
  localparam byte_t IIR_THRE = 8'h02;
  localparam byte_t IIR_RDA  = 8'h04;

  // System-to-JTAG FIFO controller
  typedef enum logic [1:0] {
    RD_IDLE  = 2'b11,
    RD_PUSH  = 2'b10,
    RD_POP   = 2'b01,
    RD_LATCH = 2'b00
  } rd_state_e;

  // JTAG-to-system FIFO controller
  typedef enum logic [1:0] {
    WR_IDLE = 2'b10,
    WR_PUSH = 2'b01,
    WR_POP  = 2'b00
  } wr_state_e;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    jsp_adr_t adr;
    byte_t    dat;
  } wb_req_s;

  typedef struct packed {
    byte_t dat;
    logic  ack;
  } wb_rsp_s;

  typedef struct packed {
    cnt_t avail;
    cnt_t free;
  } fifo_stat_s;

endpackage

//--- hdl/jsp_syncflop.sv
// Toggle-to-pulse synchronizer with sticky flag and synchronous clear
module jsp_syncflop (
  input  logic wb_clk_i,
  input  logic rst_i,
  input  logic toggle_i,
  input  logic clr_i,
  output logic pulse_o
);

  // Two sync stages, third stage keeps history
  logic [2:0] sync_q;
  logic       edge_det;
  logic       flag_q;

  // Any change of the toggle is one event
  assign edge_det = sync_q[2] ^ sync_q[1];

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      sync_q <= '0;
      flag_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[1:0], toggle_i};
      // Fresh event beats a clear in the same cycle
      if (edge_det) begin
        flag_q <= 1'b1;
      end else if (clr_i) begin
        flag_q <= 1'b0;
      end
    end
  end

  // Held until the consumer clears it
  assign pulse_o = flag_q;

endmodule

//--- hdl/jsp_syncreg.sv
// Count transfer from the Wishbone clock to TCK by a req/ack toggle handshake
module jsp_syncreg (
  input  logic          wb_clk_i,
  input  logic          tck_i,
  input  logic          rst_i,
  input  jsp_pkg::cnt_t cnt_i,
  output jsp_pkg::cnt_t cnt_o
);

  import jsp_pkg::*;

  // Source side
  cnt_t       held_q;
  logic       req_q;
  logic [1:0] ack_sync_q;
  logic       idle;

  // Destination side, stage 2 doubles as the ack toggle
  logic [2:0] req_sync_q;
  logic       req_edge;

  // Last transfer has come back acknowledged
  assign idle = (ack_sync_q[1] == req_q);

  //////////////////////
  // Wishbone side
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      held_q     <= '0;
      req_q      <= 1'b0;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[0], req_sync_q[2]};
      // Held value frozen while a transfer is in flight
      if (idle && (cnt_i != held_q)) begin
        held_q <= cnt_i;
        req_q  <= ~req_q;
      end
    end
  end

  //////////////////////
  // TCK side
  assign req_edge = req_sync_q[2] ^ req_sync_q[1];

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      req_sync_q <= '0;
      cnt_o      <= '0;
    end else begin
      req_sync_q <= {req_sync_q[1:0], req_q};
      if (req_edge) begin
        cnt_o <= held_q;
      end
    end
  end

endmodule

//--- hdl/jsp_bytefifo.sv
// Eight-entry circular byte FIFO with push/pop enable and fill counts
module jsp_bytefifo (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic                clr_i,
  input  jsp_pkg::byte_t      data_i,
  output jsp_pkg::byte_t      data_o,
  input  logic                push_i,
  input  logic                en_i,
  output jsp_pkg::fifo_stat_s stat_o
);

  import jsp_pkg::*;

  // Byte storage
  byte_t mem [FIFO_DEPTH];

  // Pointers wrap by themselves at the depth
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  cnt_t                          count_q;

  logic do_push;
  logic do_pop;

  // Push into full and pop from empty are ignored
  assign do_push = en_i & push_i & (count_q != FIFO_DEPTH);
  assign do_pop  = en_i & ~push_i & (count_q != '0);

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  //////////////////////
  // Pointers and occupancy
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      // FCR clear empties the buffer
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        count_q  <= count_q + cnt_t'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        count_q  <= count_q - cnt_t'(1);
      end
    end
  end

  // Head byte always visible
  assign data_o = mem[rd_ptr_q];

  assign stat_o.avail = count_q;
  assign stat_o.free  = FIFO_DEPTH - count_q;

endmodule

//--- hdl/jsp_uart_regs.sv
// 16550 register file, decode, IIR and LSR, THR interrupt arm, read mux, interrupt
module jsp_uart_regs (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  jsp_pkg::wb_req_s    req_i,
  input  jsp_pkg::byte_t      head_i,
  input  jsp_pkg::fifo_stat_s tx_stat_i,
  input  jsp_pkg::fifo_stat_s rx_stat_i,
  input  logic                tx_empty_evt_i,
  input  logic                fifo_ack_i,
  output logic                fifo_rd_o,
  output logic                fifo_wr_o,
  output logic                rx_clr_o,
  output logic                tx_clr_o,
  output jsp_pkg::wb_rsp_s    rsp_o,
  output logic                int_o
);

  import jsp_pkg::*;

  // Writable registers
  logic [3:0] ier_q;
  byte_t      lcr_q;
  byte_t      scr_q;
  logic       thr_arm_q;

  // Decoded access
  logic  access;
  logic  wr_acc;
  logic  rd_acc;
  logic  dlab;
  logic  data_adr;
  logic  reg_ack;
  logic  iir_read;
  logic  fcr_write;

  // Status
  logic  rx_ready;
  logic  tx_not_full;
  byte_t iir;
  byte_t lsr;

  //////////////////////
  // Decode
  assign access    = req_i.cyc & req_i.stb;
  assign wr_acc    = access & req_i.we;
  assign rd_acc    = access & ~req_i.we;
  assign dlab      = lcr_q[LCR_DLAB_BIT];
  assign data_adr  = (req_i.adr == ADR_DATA);
  assign iir_read  = rd_acc & (req_i.adr == ADR_IIR_FCR);
  assign fcr_write = wr_acc & (req_i.adr == ADR_IIR_FCR);

  // Data port goes to the FIFO controllers only with DLAB clear
  assign fifo_rd_o = rd_acc & data_adr & ~dlab;
  assign fifo_wr_o = wr_acc & data_adr & ~dlab;

  // Everything else answers at once
  assign reg_ack   = access & (dlab | ~data_adr);
  assign rsp_o.ack = reg_ack | fifo_ack_i;

  // Single cycle since the master drops stb after ack
  assign rx_clr_o = fcr_write & req_i.dat[FCR_RX_CLR_BIT];
  assign tx_clr_o = fcr_write & req_i.dat[FCR_TX_CLR_BIT];

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      ier_q <= '0;
      lcr_q <= '0;
      scr_q <= '0;
    end else if (wr_acc) begin
      unique case (req_i.adr)
        ADR_IER: begin
          // Divisor latch shadows IER while DLAB set
          if (!dlab) begin
            ier_q <= req_i.dat[3:0];
          end
        end
        ADR_LCR: lcr_q <= req_i.dat;
        ADR_SCR: scr_q <= req_i.dat;
        default: ;
      endcase
    end
  end

  //////////////////////
  // Status and IIR
  assign rx_ready    = (rx_stat_i.avail != '0);
  assign tx_not_full = (tx_stat_i.avail != FIFO_DEPTH);

  // Bits 5 and 6 both track transmit space
  assign lsr = {1'b0, tx_not_full, tx_not_full, 4'h0, rx_ready};

  // Armed by a data write or by the last byte leaving
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      thr_arm_q <= 1'b0;
    end else if (fifo_wr_o || tx_empty_evt_i) begin
      thr_arm_q <= 1'b1;
    end else if (iir_read && !rx_ready) begin
      thr_arm_q <= 1'b0;
    end
  end

  // Received data first, then transmitter
  always_comb begin
    if (rx_ready) begin
      iir = IIR_RDA;
    end else if (thr_arm_q && tx_not_full) begin
      iir = IIR_THRE;
    end else begin
      iir = IIR_NONE;
    end
  end

  //////////////////////
  // Read mux
  always_comb begin
    unique case (req_i.adr)
      ADR_DATA:    rsp_o.dat = head_i;
      ADR_IER:     rsp_o.dat = {4'h0, ier_q};
      ADR_IIR_FCR: rsp_o.dat = iir;
      ADR_LCR:     rsp_o.dat = lcr_q;
      ADR_MCR:     rsp_o.dat = '0;
      ADR_LSR:     rsp_o.dat = lsr;
      ADR_MSR:     rsp_o.dat = MSR_CONST;
      ADR_SCR:     rsp_o.dat = scr_q;
      default:     rsp_o.dat = '0;
    endcase
  end

  assign int_o = (rx_ready & ier_q[0]) | (tx_not_full & thr_arm_q & ier_q[1]);

endmodule

//--- hdl/jsp_biu_wb.sv
// JTAG serial port bus interface top with TCK latches, FIFO controllers and all blocks
module jsp_biu_wb (
  input  logic             wb_clk_i,
  input  logic             tck_i,
  input  logic             rst_i,
  input  jsp_pkg::byte_t   data_i,
  input  logic             rd_strobe_i,
  input  logic             wr_strobe_i,
  output jsp_pkg::byte_t   data_o,
  output jsp_pkg::cnt_t    bytes_available_o,
  output jsp_pkg::cnt_t    bytes_free_o,
  input  jsp_pkg::wb_req_s wb_req_i,
  output jsp_pkg::wb_rsp_s wb_rsp_o,
  output logic             int_o
);

  import jsp_pkg::*;

  // TCK side
  byte_t      data_in_q;
  logic       wen_tff_q;
  logic       ren_tff_q;

  // FIFO status, rx is JTAG-to-system, tx is system-to-JTAG
  fifo_stat_s rx_stat;
  fifo_stat_s tx_stat;
  byte_t      rx_head;
  byte_t      tx_head;
  byte_t      rdata_q;

  // Register file handshake
  logic       fifo_rd;
  logic       fifo_wr;
  logic       fifo_ack;
  logic       rx_clr;
  logic       tx_clr;
  logic       tx_empty_evt;

  // Synchronized strobes
  logic       wdata_avail;
  logic       ren_flag;
  logic       rcz;
  logic       pop;

  // Controller outputs
  rd_state_e  rd_state_q;
  rd_state_e  rd_state_d;
  wr_state_e  wr_state_q;
  wr_state_e  wr_state_d;
  logic       ren_clr;
  logic       rpp;
  logic       r_fifo_en;
  logic       rdata_en;
  logic       r_ack;
  logic       wda_clr;
  logic       wpp;
  logic       w_fifo_en;
  logic       w_ack;

  ////////////////////
  // TCK domain
  // Strobes become toggles, incoming byte held until next strobe
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wen_tff_q <= 1'b0;
      ren_tff_q <= 1'b0;
      data_in_q <= '0;
    end else begin
      if (wr_strobe_i) begin
        wen_tff_q <= ~wen_tff_q;
        data_in_q <= data_i;
      end
      if (rd_strobe_i) begin
        ren_tff_q <= ~ren_tff_q;
      end
    end
  end

  ////////////////////
  // Crossings
  jsp_syncflop u_wen_sync (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .toggle_i (wen_tff_q),
    .clr_i    (wda_clr),
    .pulse_o  (wdata_avail)
  );

  jsp_syncflop u_ren_sync (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .toggle_i (ren_tff_q),
    .clr_i    (ren_clr),
    .pulse_o  (ren_flag)
  );

  // Free space of the JTAG-to-system FIFO back to TCK
  jsp_syncreg u_free_sync (
    .wb_clk_i (wb_clk_i),
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .cnt_i    (rx_stat.free),
    .cnt_o    (bytes_free_o)
  );

  jsp_syncreg u_avail_sync (
    .wb_clk_i (wb_clk_i),
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .cnt_i    (tx_stat.avail),
    .cnt_o    (bytes_available_o)
  );

  ////////////////////
  // FIFOs
  jsp_bytefifo u_rx_fifo (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .clr_i    (rx_clr),
    .data_i   (data_in_q),
    .data_o   (rx_head),
    .push_i   (wpp),
    .en_i     (w_fifo_en),
    .stat_o   (rx_stat)
  );

  jsp_bytefifo u_tx_fifo (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .clr_i    (tx_clr),
    .data_i   (wb_req_i.dat),
    .data_o   (tx_head),
    .push_i   (rpp),
    .en_i     (r_fifo_en),
    .stat_o   (tx_stat)
  );

  jsp_uart_regs u_regs (
    .wb_clk_i       (wb_clk_i),
    .rst_i          (rst_i),
    .req_i          (wb_req_i),
    .head_i         (rx_head),
    .tx_stat_i      (tx_stat),
    .rx_stat_i      (rx_stat),
    .tx_empty_evt_i (tx_empty_evt),
    .fifo_ack_i     (fifo_ack),
    .fifo_rd_o      (fifo_rd),
    .fifo_wr_o      (fifo_wr),
    .rx_clr_o       (rx_clr),
    .tx_clr_o       (tx_clr),
    .rsp_o          (wb_rsp_o),
    .int_o          (int_o)
  );

  ////////////////////
  // System-to-JTAG controller
  assign rcz = (tx_stat.avail == '0);
  assign pop = ren_flag & ~rcz;

  // Last byte leaving rearms the transmit interrupt
  assign tx_empty_evt = r_fifo_en & ~rpp & (tx_stat.avail == cnt_t'(1));

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_state_q <= RD_IDLE;
    end else begin
      rd_state_q <= rd_state_d;
    end
  end

  always_comb begin
    rd_state_d = RD_IDLE;
    unique case (rd_state_q)
      RD_IDLE, RD_LATCH: begin
        if (fifo_wr) begin
          rd_state_d = RD_PUSH;
        end else if (pop) begin
          rd_state_d = RD_POP;
        end
      end
      RD_PUSH: begin
        // First byte into empty FIFO goes straight to data_o
        if (rcz) begin
          rd_state_d = RD_LATCH;
        end else if (pop) begin
          rd_state_d = RD_POP;
        end
      end
      // New head after the pop
      RD_POP:  rd_state_d = RD_LATCH;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  assign rpp       = (rd_state_q == RD_PUSH);
  assign r_ack     = (rd_state_q == RD_PUSH);
  assign r_fifo_en = (rd_state_q == RD_PUSH) | (rd_state_q == RD_POP);
  assign rdata_en  = (rd_state_q == RD_LATCH);
  // Strobe with nothing to pop is dropped
  assign ren_clr   = (rd_state_q == RD_POP) | (ren_flag & rcz);

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (rdata_en) begin
      rdata_q <= tx_head;
    end
  end

  assign data_o = rdata_q;

  ////////////////////
  // JTAG-to-system controller
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_state_q <= WR_IDLE;
    end else begin
      wr_state_q <= wr_state_d;
    end
  end

  always_comb begin
    wr_state_d = WR_IDLE;
    unique case (wr_state_q)
      WR_IDLE: begin
        // Bus read wins over pending push
        if (fifo_rd) begin
          wr_state_d = WR_POP;
        end else if (wdata_avail) begin
          wr_state_d = WR_PUSH;
        end
      end
      WR_PUSH: begin
        if (fifo_rd) begin
          wr_state_d = WR_POP;
        end
      end
      WR_POP: begin
        if (wdata_avail) begin
          wr_state_d = WR_PUSH;
        end
      end
      default: wr_state_d = WR_IDLE;
    endcase
  end

  assign wpp       = (wr_state_q == WR_PUSH);
  assign wda_clr   = (wr_state_q == WR_PUSH);
  assign w_ack     = (wr_state_q == WR_POP);
  assign w_fifo_en = (wr_state_q == WR_PUSH) | (wr_state_q == WR_POP);

  // Either controller completes a data-port access
  assign fifo_ack = r_ack | w_ack;

endmodule

//--- bench/tb_clkgen.sv
// Testbench clock and reset generator for the Wishbone clock and TCK
module tb_clkgen (
  output logic wb_clk_o,
  output logic tck_o,
  output logic rst_o
);

  // Wishbone clock, period 40
  initial begin
    wb_clk_o = 1'b0;
    forever #20 wb_clk_o = ~wb_clk_o;
  end

  // TCK, period 56, unrelated to the bus clock
  initial begin
    tck_o = 1'b0;
    forever #28 tck_o = ~tck_o;
  end

  // Reset for 10 bus cycles, released away from the rising edge
  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge wb_clk_o);
    @(negedge wb_clk_o);
    rst_o = 1'b0;
  end

endmodule

//--- bench/tb_jsp.sv
// Testbench top for the JTAG serial port bus interface with FIFO and register models
module tb_jsp;

  import jsp_pkg::*;

  logic       wb_clk;
  logic       tck;
  logic       rst;
  byte_t      jdata;
  logic       rd_strobe;
  logic       wr_strobe;
  byte_t      data_out;
  cnt_t       bytes_avail;
  cnt_t       bytes_free;
  wb_req_s    req;
  wb_rsp_s    rsp;
  logic       irq;

  // Test operations as read from the data file
  int         op_q[$];
  int         arg_q[$];
  int         dat_q[$];
  int         exp_q[$];

  // FIFO models
  // Front of tx_q is the byte latched on data_o
  byte_t      rx_q[$];
  byte_t      tx_q[$];
  logic       dlab;
  int         errors;
  int         cycles;
  int         limit;

  tb_clkgen u_clkgen (
    .wb_clk_o (wb_clk),
    .tck_o    (tck),
    .rst_o    (rst)
  );

  jsp_biu_wb dut_i (
    .wb_clk_i          (wb_clk),
    .tck_i             (tck),
    .rst_i             (rst),
    .data_i            (jdata),
    .rd_strobe_i       (rd_strobe),
    .wr_strobe_i       (wr_strobe),
    .data_o            (data_out),
    .bytes_available_o (bytes_avail),
    .bytes_free_o      (bytes_free),
    .wb_req_i          (req),
    .wb_rsp_o          (rsp),
    .int_o             (irq)
  );

  task automatic check_val(input string name, input int expv, input int actv);
    if (expv != actv) begin
      errors++;
      $display("** Error %s: expected %0h, actual %0h", name, expv, actv);
    end
  endtask

  ////////////////////
  // Bus and JTAG drivers
  // Access held until ack and dropped on the next rising edge
  task automatic bus_access(input logic we, input jsp_adr_t adr, input byte_t dat,
                            output byte_t rdat, output int lat);
    @(posedge wb_clk);
    req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    lat = 0;
    do begin
      @(negedge wb_clk);
      lat++;
    end while (!rsp.ack);
    rdat = rsp.dat;
    @(posedge wb_clk);
    req <= '0;
  endtask

  // One TCK cycle wide strobe
  task automatic jtag_strobe(input logic rd, input byte_t dat);
    @(posedge tck);
    if (rd) begin
      rd_strobe <= 1'b1;
    end else begin
      wr_strobe <= 1'b1;
      jdata     <= dat;
    end
    @(posedge tck);
    rd_strobe <= 1'b0;
    wr_strobe <= 1'b0;
  endtask

  // TCK-side counts match the models for 16 TCK cycles in a row
  // Window outlasts the slowest count transfer
  task automatic wait_counts();
    int stable;
    stable = 0;
    while (stable < 16) begin
      @(negedge tck);
      if (bytes_avail == cnt_t'(tx_q.size()) &&
          bytes_free == cnt_t'(8 - rx_q.size())) begin
        stable++;
      end else begin
        stable = 0;
      end
    end
    @(negedge wb_clk);
    if (tx_q.size() > 0) begin
      check_val("data_o", int'(tx_q[0]), int'(data_out));
    end
  endtask

  ////////////////////
  // One line of the data file
  task automatic run_op(input int idx);
    string name;
    byte_t rdat;
    byte_t b;
    int    lat;
    jsp_adr_t adr;
    adr  = jsp_adr_t'(arg_q[idx]);
    b    = byte_t'(dat_q[idx]);
    name = $sformatf("op %0d (code %0d adr %0d)", idx, op_q[idx], arg_q[idx]);
    case (op_q[idx])
      1: begin
        for (int i = 0; i < arg_q[idx]; i++) begin
          jtag_strobe(1'b0, b);
          rx_q.push_back(b);
          wait_counts();
          b = b + 8'd1;
        end
      end
      2, 8: begin
        // Code 8 repeats data writes with incrementing bytes
        for (int i = 0; i < ((op_q[idx] == 8) ? arg_q[idx] : 1); i++) begin
          if (op_q[idx] == 8) begin
            adr = ADR_DATA;
          end
          bus_access(1'b1, adr, b, rdat, lat);
          if (adr == ADR_DATA && !dlab) begin
            if (tx_q.size() < 8) begin
              tx_q.push_back(b);
            end
          end else begin
            check_val({name, " write latency"}, 1, lat);
          end
          if (adr == ADR_LCR) begin
            dlab = b[LCR_DLAB_BIT];
          end
          if (adr == ADR_IIR_FCR && b[FCR_RX_CLR_BIT]) begin
            rx_q.delete();
          end
          if (adr == ADR_IIR_FCR && b[FCR_TX_CLR_BIT]) begin
            tx_q.delete();
          end
          b = b + 8'd1;
        end
      end
      3: begin
        bus_access(1'b0, adr, 8'h00, rdat, lat);
        check_val(name, exp_q[idx], int'(rdat));
        check_val({name, " read latency"}, 1, lat);
      end
      4: begin
        bus_access(1'b0, ADR_DATA, 8'h00, rdat, lat);
        // Empty FIFO gives an undefined byte
        if (dlab) begin
          check_val({name, " latency"}, 1, lat);
          if (rx_q.size() > 0) begin
            check_val(name, int'(rx_q[0]), int'(rdat));
          end
        end else if (rx_q.size() > 0) begin
          check_val(name, int'(rx_q.pop_front()), int'(rdat));
        end
      end
      5: begin
        jtag_strobe(1'b1, 8'h00);
        if (tx_q.size() > 0) begin
          void'(tx_q.pop_front());
        end
        wait_counts();
      end
      6: wait_counts();
      7: begin
        repeat (2) @(posedge wb_clk);
        @(negedge wb_clk);
        check_val({name, " int_o"}, exp_q[idx], int'(irq));
      end
      default: begin
        errors++;
        $display("Unknown operation code %0d in test data line %0d", op_q[idx], idx);
      end
    endcase
  endtask

  task automatic load_tests();
    int    fd;
    int    rc;
    int    o;
    int    a;
    int    d;
    int    e;
    string line;
    fd = $fopen("bench/jsp_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file bench/jsp_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        // Comment lines start with a hash
        if (rc > 0 && line.len() > 0 && line[0] != 8'h23) begin
          if ($sscanf(line, "%h %h %h %h", o, a, d, e) == 4) begin
            op_q.push_back(o);
            arg_q.push_back(a);
            dat_q.push_back(d);
            exp_q.push_back(e);
            limit += ((o == 1 || o == 8) ? a : 1) * 64;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Watchdog in bus cycles
  always @(posedge wb_clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Run hung: no progress within %0d bus cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    jdata     = '0;
    rd_strobe = 1'b0;
    wr_strobe = 1'b0;
    req       = '0;
    dlab      = 1'b0;
    errors    = 0;
    cycles    = 0;
    limit     = 0;
    load_tests();
    @(negedge rst);
    repeat (2) @(posedge wb_clk);
    if (op_q.size() == 0) begin
      errors++;
      $display("No test operations were read");
    end
    for (int i = 0; i < op_q.size(); i++) begin
      run_op(i);
    end
    $display("Operations: %0d, errors: %0d", op_q.size(), errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
hdl/jsp_pkg.sv
hdl/jsp_syncflop.sv
hdl/jsp_syncreg.sv
hdl/jsp_bytefifo.sv
hdl/jsp_uart_regs.sv
hdl/jsp_biu_wb.sv
bench/tb_clkgen.sv
bench/tb_jsp.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run from the project root
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_jsp -o tb_jsp \
  > build.log 2>&1 \
  && ./obj_dir/tb_jsp > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^TESTBENCH PASSED$" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- bench/jsp_testdata.txt
# op adr/count data expected, hex. op 1 jtag writes, 2 bus write, 3 register read,
# 4 data read, 5 jtag read strobe, 6 settle counts, 7 int_o check, 8 bus data writes
1 3 11 0
3 5 0 61
4 0 0 0
4 0 0 0
4 0 0 0
3 5 0 60
2 0 a1 0
2 0 b2 0
2 0 c3 0
6 0 0 0
5 0 0 0
5 0 0 0
5 0 0 0
6 0 0 0
8 8 40 0
3 5 0 00
6 0 0 0
5 0 0 0
3 5 0 60
1 8 80 0
2 7 5a 0
3 7 0 5a
2 3 03 0
3 3 0 03
3 4 0 00
3 6 0 0b
2 3 80 0
2 1 0f 0
2 0 77 0
4 0 0 0
6 0 0 0
2 3 03 0
3 1 0 00
2 2 06 0
3 5 0 60
6 0 0 0
3 2 0 02
3 2 0 01
2 1 03 0
7 0 0 0
1 1 5c 0
7 0 0 1
3 2 0 04
2 0 99 0
4 0 0 0
3 2 0 02
3 2 0 01
7 0 0 0
